//--- bench/csr_unit_tasks.svh
// rs1 and rd fields are ignored by the unit, the core resolves the operand
task automatic drive_csr(input logic [1:0] op, input logic [CSR_ADDR_WIDTH-1:0] addr,
                         input logic imm, input logic [31:0] wdata);
    @(negedge clock);
    i_valid     = 1'b1;
    i_inst      = {addr, 5'd1, imm, op, 5'd2, OPCODE_SYSTEM};
    i_csr_wdata = wdata;
endtask

task automatic drive_ecall(input logic [31:0] pc);
    @(negedge clock);
    i_valid = 1'b1;
    i_inst  = INST_ECALL;
    i_pc    = pc;
endtask

task automatic drive_mret();
    @(negedge clock);
    i_valid = 1'b1;
    i_inst  = INST_MRET;
endtask

task automatic drive_other(input logic valid, input logic [31:0] inst);
    @(negedge clock);
    i_valid = valid;
    i_inst  = inst;
endtask

task automatic drive_idle();
    drive_other(1'b0, 32'h0000_0000);
endtask

// csrrs with a zero operand reads without changing anything
task automatic read_writable();
    for (int i = 0; i < NUM_CELLS; i++) begin
        drive_csr(OP_RS, writable_addr[i], 1'b0, 32'h0);
    end
endtask

task automatic random_csr_op();
    logic [31:0] pick;
    logic [31:0] op_bits;
    logic [31:0] imm_bit;
    logic [31:0] data;
    take_bits(3, pick);
    take_bits(2, op_bits);
    take_bits(1, imm_bit);
    take_bits(32, data);
    // funct3 low bits 00 is not a csr op
    if (op_bits[1:0] == 2'b00) begin
        op_bits = 32'd1;
    end
    drive_csr(op_bits[1:0], writable_addr[pick % NUM_CELLS], imm_bit[0], data);
endtask

task automatic check_read_only();
    logic [31:0] data;
    take_bits(32, data);
    drive_csr(OP_RW, ADDR_MVENDORID, 1'b0, data);
    drive_csr(OP_RS, ADDR_MARCHID, 1'b1, data);
    drive_csr(OP_RS, ADDR_MVENDORID, 1'b0, 32'h0);
    drive_csr(OP_RS, ADDR_MARCHID, 1'b0, 32'h0);
    // unused address, then a plain alu op and an invalid csr op
    drive_csr(OP_RW, 12'h7C0, 1'b0, data);
    drive_csr(OP_RS, 12'h7C0, 1'b0, 32'h0);
    drive_other(1'b1, 32'h0010_0093);
    drive_other(1'b0, {ADDR_MSCRATCH, 5'd1, 3'b001, 5'd2, OPCODE_SYSTEM});
    drive_idle();
    read_writable();
endtask

// each instruction relies on the one just before it
task automatic back_to_back(input int rounds);
    logic [31:0] data;
    logic [31:0] pc;
    repeat (rounds) begin
        take_bits(32, data);
        take_bits(32, pc);
        drive_csr(OP_RW, ADDR_MEPC, 1'b0, data);
        drive_ecall(pc);
        drive_csr(OP_RS, ADDR_MEPC, 1'b0, 32'h0);
        drive_mret();
        drive_csr(OP_RS, ADDR_MSTATUS, 1'b0, 32'h0);
    end
endtask

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int CLOCK_PERIOD   = 40;
    localparam int RANDOM_OPS     = 120;
    // rough length of the whole sequence in cycles
    localparam int TEST_CYCLES    = 240;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES + 40;

    logic                  clock;
    logic                  reset;
    logic                  i_valid;
    logic [DATA_WIDTH-1:0] i_inst;
    logic [DATA_WIDTH-1:0] i_pc;
    logic [DATA_WIDTH-1:0] i_csr_wdata;
    logic [DATA_WIDTH-1:0] o_csr_rdata;
    logic [DATA_WIDTH-1:0] o_mstatus;
    logic [DATA_WIDTH-1:0] o_mtvec;
    logic [DATA_WIDTH-1:0] o_mepc;

    // shadow copies of the writable csrs
    logic [DATA_WIDTH-1:0] m_mstatus;
    logic [DATA_WIDTH-1:0] m_mtvec;
    logic [DATA_WIDTH-1:0] m_mepc;
    logic [DATA_WIDTH-1:0] m_mcause;
    logic [DATA_WIDTH-1:0] m_mscratch;
    logic [DATA_WIDTH-1:0] exp_rdata;
    logic                  exp_access;

    logic [CSR_ADDR_WIDTH-1:0] writable_addr [NUM_CELLS] = '{
        ADDR_MSTATUS, ADDR_MTVEC, ADDR_MEPC, ADDR_MCAUSE, ADDR_MSCRATCH
    };

    logic [31:0] lfsr_state   = 32'd70652;
    int          read_errors  = 0;
    int          state_errors = 0;
    int          cycle_count  = 0;

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    csr_unit csr_unit_inst (
        .clock       (clock),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_csr_wdata (i_csr_wdata),
        .o_csr_rdata (o_csr_rdata),
        .o_mstatus   (o_mstatus),
        .o_mtvec     (o_mtvec),
        .o_mepc      (o_mepc)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] apply_op(input logic [31:0] old, input logic [1:0] op,
                                             input logic [31:0] wdata);
        case (op)
            2'b01:   return wdata;
            2'b10:   return old | wdata;
            2'b11:   return old & ~wdata;
            default: return old;
        endcase
    endfunction

    task automatic report_mismatch(input bit is_state, input string name,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR at %0t ns: %s expected %08h, got %08h", $time, name, expected, actual);
        if (is_state) begin
            state_errors++;
        end else begin
            read_errors++;
        end
    endtask

    `include "csr_unit_tasks.svh"

    // old value of the addressed csr, zero outside a valid csr access
    assign exp_access = i_valid && !reset && (i_inst[6:0] == OPCODE_SYSTEM)
                     && (i_inst[14:12] != 3'b000);

    always_comb begin
        exp_rdata = '0;
        if (exp_access) begin
            case (i_inst[31:20])
                ADDR_MSTATUS:   exp_rdata = m_mstatus;
                ADDR_MTVEC:     exp_rdata = m_mtvec;
                ADDR_MEPC:      exp_rdata = m_mepc;
                ADDR_MCAUSE:    exp_rdata = m_mcause;
                ADDR_MSCRATCH:  exp_rdata = m_mscratch;
                ADDR_MVENDORID: exp_rdata = 32'h0000_0000;
                ADDR_MARCHID:   exp_rdata = 32'h0165_A9D3;
                default:        exp_rdata = '0;
            endcase
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            m_mstatus  <= '0;
            m_mtvec    <= '0;
            m_mepc     <= '0;
            m_mcause   <= '0;
            m_mscratch <= '0;
        end else if (i_valid && i_inst == 32'h0000_0073) begin
            m_mepc    <= i_pc;
            m_mcause  <= 32'd11;
            m_mstatus <= m_mstatus | 32'h0000_1800;
        end else if (i_valid && i_inst == 32'h3020_0073) begin
            m_mstatus <= m_mstatus & ~32'h0000_1800;
        end else if (exp_access) begin
            case (i_inst[31:20])
                ADDR_MSTATUS:  m_mstatus  <= apply_op(m_mstatus, i_inst[13:12], i_csr_wdata);
                ADDR_MTVEC:    m_mtvec    <= apply_op(m_mtvec, i_inst[13:12], i_csr_wdata);
                ADDR_MEPC:     m_mepc     <= apply_op(m_mepc, i_inst[13:12], i_csr_wdata);
                ADDR_MCAUSE:   m_mcause   <= apply_op(m_mcause, i_inst[13:12], i_csr_wdata);
                ADDR_MSCRATCH: m_mscratch <= apply_op(m_mscratch, i_inst[13:12], i_csr_wdata);
                default:       m_mcause   <= m_mcause;
            endcase
        end
    end

    rdata_matches: assert property (@(posedge clock) o_csr_rdata == exp_rdata)
        else report_mismatch(1'b0, "o_csr_rdata", $sampled(exp_rdata), $sampled(o_csr_rdata));

    mstatus_matches: assert property (@(posedge clock) disable iff (reset) o_mstatus == m_mstatus)
        else report_mismatch(1'b1, "o_mstatus", $sampled(m_mstatus), $sampled(o_mstatus));

    mtvec_matches: assert property (@(posedge clock) disable iff (reset) o_mtvec == m_mtvec)
        else report_mismatch(1'b1, "o_mtvec", $sampled(m_mtvec), $sampled(o_mtvec));

    mepc_matches: assert property (@(posedge clock) disable iff (reset) o_mepc == m_mepc)
        else report_mismatch(1'b1, "o_mepc", $sampled(m_mepc), $sampled(o_mepc));

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] data;
        logic [31:0] pc;
        reset       = 1'b1;
        // marchid read held through reset, read data must stay zero
        i_valid     = 1'b1;
        i_inst      = {ADDR_MARCHID, 5'd0, 3'b010, 5'd0, OPCODE_SYSTEM};
        i_pc        = '0;
        i_csr_wdata = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        read_writable();
        repeat (RANDOM_OPS) random_csr_op();
        read_writable();
        check_read_only();

        // ecall on top of random mstatus contents
        take_bits(32, data);
        drive_csr(OP_RW, ADDR_MSTATUS, 1'b0, data & ~MSTATUS_MPP_MASK);
        take_bits(32, pc);
        drive_ecall(pc);
        read_writable();

        // mret keeps everything except mpp
        take_bits(32, data);
        drive_csr(OP_RW, ADDR_MSTATUS, 1'b0, data | MSTATUS_MPP_MASK);
        drive_mret();
        read_writable();

        back_to_back(4);
        repeat (3) drive_idle();
        @(negedge clock);

        $display("checks failed: %0d read data, %0d register state", read_errors, state_errors);
        if (read_errors + state_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- csr_unit.f
+incdir+bench
hdl/csr_pkg.sv
hdl/csr_cell.sv
hdl/csr_decode.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
bench/csr_unit_tb.sv

//--- hdl/csr_cell.sv
`timescale 1ns/1ps

module csr_cell
    import csr_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  cell_cmd_t             i_cmd,
    output logic [DATA_WIDTH-1:0] o_value
);

    logic [DATA_WIDTH-1:0] value_q;

    // trap load wins over a csr write
    always_ff @(posedge clock) begin
        if (reset) begin
            value_q <= '0;
        end else if (i_cmd.trap_load) begin
            value_q <= i_cmd.trap_value;
        end else if (i_cmd.write) begin
            case (i_cmd.op)
                OP_RW: begin
                    value_q <= i_cmd.wdata;
                end
                OP_RS: begin
                    value_q <= value_q | i_cmd.wdata;
                end
                OP_RC: begin
                    value_q <= value_q & ~i_cmd.wdata;
                end
                default: begin
                    value_q <= value_q;
                end
            endcase
        end
    end

    assign o_value = value_q;

    // decoder must resolve trap priority before the command gets here
    write_vs_trap: assert property (
        @(posedge clock) disable iff (reset)
        !(i_cmd.write && i_cmd.trap_load)
    );

    // funct3 000 is ecall/mret, never a write
    write_has_op: assert property (
        @(posedge clock) disable iff (reset)
        i_cmd.write |-> (i_cmd.op != OP_NONE)
    );

endmodule

//--- hdl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode
    import csr_pkg::*;
(
    input  logic                  [DATA_WIDTH-1:0] i_inst,
    input  logic                  [DATA_WIDTH-1:0] i_pc,
    input  logic                  [DATA_WIDTH-1:0] i_csr_wdata,
    input  logic                                   i_valid,
    input  cell_bus_t                              i_cells,
    output cell_cmd_t             [NUM_CELLS-1:0]  o_cmd
);

    logic                  is_system;
    logic                  csr_access;
    logic                  is_ecall;
    logic                  is_mret;
    csr_op_e               op;
    csr_addr_e             addr;
    logic [NUM_CELLS-1:0]  addr_hit;
    logic [DATA_WIDTH-1:0] mstatus_cur;

    assign is_system  = (i_inst[6:0] == OPCODE_SYSTEM);
    assign csr_access = i_valid && is_system && (i_inst[14:12] != FUNCT3_PRIV);
    assign is_ecall   = i_valid && (i_inst == INST_ECALL);
    assign is_mret    = i_valid && (i_inst == INST_MRET);

    assign op   = csr_op_e'(i_inst[13:12]);
    assign addr = csr_addr_e'(i_inst[31:20]);

    assign mstatus_cur = i_cells[SLOT_MSTATUS];

    // address to one-hot slot
    // id registers and unknown addresses hit no cell
    always_comb begin
        addr_hit = '0;
        case (addr)
            ADDR_MSTATUS: begin
                addr_hit[SLOT_MSTATUS] = 1'b1;
            end
            ADDR_MTVEC: begin
                addr_hit[SLOT_MTVEC] = 1'b1;
            end
            ADDR_MEPC: begin
                addr_hit[SLOT_MEPC] = 1'b1;
            end
            ADDR_MCAUSE: begin
                addr_hit[SLOT_MCAUSE] = 1'b1;
            end
            ADDR_MSCRATCH: begin
                addr_hit[SLOT_MSCRATCH] = 1'b1;
            end
            default: begin
                addr_hit = '0;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < NUM_CELLS; i++) begin
            o_cmd[i].write      = csr_access && addr_hit[i];
            o_cmd[i].op         = op;
            o_cmd[i].wdata      = i_csr_wdata;
            o_cmd[i].trap_load  = 1'b0;
            o_cmd[i].trap_value = '0;
        end

        // ecall saves pc and cause and sets mpp
        if (is_ecall) begin
            o_cmd[SLOT_MEPC].trap_load     = 1'b1;
            o_cmd[SLOT_MEPC].trap_value    = i_pc;
            o_cmd[SLOT_MCAUSE].trap_load   = 1'b1;
            o_cmd[SLOT_MCAUSE].trap_value  = CAUSE_ECALL_M;
            o_cmd[SLOT_MSTATUS].trap_load  = 1'b1;
            o_cmd[SLOT_MSTATUS].trap_value = mstatus_cur | MSTATUS_MPP_MASK;
        end else if (is_mret) begin
            o_cmd[SLOT_MSTATUS].trap_load  = 1'b1;
            o_cmd[SLOT_MSTATUS].trap_value = mstatus_cur & ~MSTATUS_MPP_MASK;
        end

        // a trap load masks the write in the same cell
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (o_cmd[i].trap_load) begin
                o_cmd[i].write = 1'b0;
            end
        end
    end

endmodule

//--- hdl/csr_pkg.sv
package csr_pkg;

    // data, pc and instruction share one width
    localparam int DATA_WIDTH     = 32;
    localparam int CSR_ADDR_WIDTH = 12;

    // machine-mode csr addresses handled by the unit
    typedef enum logic [CSR_ADDR_WIDTH-1:0] {
        ADDR_MSTATUS   = 12'h300,
        ADDR_MTVEC     = 12'h305,
        ADDR_MSCRATCH  = 12'h340,
        ADDR_MEPC      = 12'h341,
        ADDR_MCAUSE    = 12'h342,
        ADDR_MVENDORID = 12'hF11,
        ADDR_MARCHID   = 12'hF12
    } csr_addr_e;

    // funct3[1:0] of the csr instructions
    // the immediate forms share these codes, the core resolves zimm
    typedef enum logic [1:0] {
        OP_NONE = 2'b00,
        OP_RW   = 2'b01,
        OP_RS   = 2'b10,
        OP_RC   = 2'b11
    } csr_op_e;

    // cell array layout
    localparam int NUM_CELLS     = 5;
    localparam int SLOT_MSTATUS  = 0;
    localparam int SLOT_MTVEC    = 1;
    localparam int SLOT_MEPC     = 2;
    localparam int SLOT_MCAUSE   = 3;
    localparam int SLOT_MSCRATCH = 4;

    // instruction encodings
    localparam logic [6:0]            OPCODE_SYSTEM = 7'b1110011;
    localparam logic [2:0]            FUNCT3_PRIV   = 3'b000;
    localparam logic [DATA_WIDTH-1:0] INST_ECALL    = 32'h0000_0073;
    localparam logic [DATA_WIDTH-1:0] INST_MRET     = 32'h3020_0073;

    // mstatus.mpp, bits 12:11
    localparam logic [DATA_WIDTH-1:0] MSTATUS_MPP_MASK = 32'h0000_1800;

    // environment call from m-mode
    localparam logic [DATA_WIDTH-1:0] CAUSE_ECALL_M = 32'd11;

    // read-only id registers
    localparam logic [DATA_WIDTH-1:0] MVENDORID_VALUE = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] MARCHID_VALUE   = 32'h0165_A9D3;

    // command to one register cell, 68 bits
    typedef struct packed {
        logic                  write;
        csr_op_e               op;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  trap_load;
        logic [DATA_WIDTH-1:0] trap_value;
    } cell_cmd_t;

    // current contents of every cell, indexed by slot
    typedef logic [NUM_CELLS-1:0][DATA_WIDTH-1:0] cell_bus_t;

endpackage

//--- hdl/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
(
    input  logic      [DATA_WIDTH-1:0] i_inst,
    input  logic                       i_valid,
    input  cell_bus_t                  i_cells,
    output logic      [DATA_WIDTH-1:0] o_csr_rdata
);

    logic      csr_access;
    csr_addr_e addr;

    // same access rule as the decoder
    assign csr_access = i_valid
                     && (i_inst[6:0] == OPCODE_SYSTEM)
                     && (i_inst[14:12] != FUNCT3_PRIV);

    assign addr = csr_addr_e'(i_inst[31:20]);

    // old value of the addressed csr, before this cycle's update
    always_comb begin
        o_csr_rdata = '0;
        if (csr_access) begin
            case (addr)
                ADDR_MSTATUS: begin
                    o_csr_rdata = i_cells[SLOT_MSTATUS];
                end
                ADDR_MTVEC: begin
                    o_csr_rdata = i_cells[SLOT_MTVEC];
                end
                ADDR_MEPC: begin
                    o_csr_rdata = i_cells[SLOT_MEPC];
                end
                ADDR_MCAUSE: begin
                    o_csr_rdata = i_cells[SLOT_MCAUSE];
                end
                ADDR_MSCRATCH: begin
                    o_csr_rdata = i_cells[SLOT_MSCRATCH];
                end
                // read-only ids
                ADDR_MVENDORID: begin
                    o_csr_rdata = MVENDORID_VALUE;
                end
                ADDR_MARCHID: begin
                    o_csr_rdata = MARCHID_VALUE;
                end
                default: begin
                    o_csr_rdata = '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  i_valid,
    input  logic [DATA_WIDTH-1:0] i_inst,
    input  logic [DATA_WIDTH-1:0] i_pc,
    input  logic [DATA_WIDTH-1:0] i_csr_wdata,
    output logic [DATA_WIDTH-1:0] o_csr_rdata,
    output logic [DATA_WIDTH-1:0] o_mstatus,
    output logic [DATA_WIDTH-1:0] o_mtvec,
    output logic [DATA_WIDTH-1:0] o_mepc
);

    cell_cmd_t [NUM_CELLS-1:0] cmd;
    cell_bus_t                 cells;
    logic                      read_valid;

    csr_decode csr_decode_inst (
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_csr_wdata (i_csr_wdata),
        .i_valid     (i_valid),
        .i_cells     (cells),
        .o_cmd       (cmd)
    );

    // one cell per writable csr, slot order from the package
    for (genvar g = 0; g < NUM_CELLS; g++) begin : g_cell
        csr_cell csr_cell_inst (
            .clock   (clock),
            .reset   (reset),
            .i_cmd   (cmd[g]),
            .o_value (cells[g])
        );
    end

    // read data forced to zero while reset is held
    assign read_valid = i_valid && !reset;

    csr_read_mux csr_read_mux_inst (
        .i_inst      (i_inst),
        .i_valid     (read_valid),
        .i_cells     (cells),
        .o_csr_rdata (o_csr_rdata)
    );

    // to fetch logic
    assign o_mstatus = cells[SLOT_MSTATUS];
    assign o_mtvec   = cells[SLOT_MTVEC];
    assign o_mepc    = cells[SLOT_MEPC];

    // ecall lands pc in mepc one cycle later
    ecall_saves_pc: assert property (
        @(posedge clock) disable iff (reset)
        (i_valid && i_inst == INST_ECALL) |=> (o_mepc == $past(i_pc))
    );

    // mret leaves mpp clear on the next cycle
    mret_clears_mpp: assert property (
        @(posedge clock) disable iff (reset)
        (i_valid && i_inst == INST_MRET) |=> ((o_mstatus & MSTATUS_MPP_MASK) == '0)
    );

endmodule
